// ==== rtl/hist_defines.svh ====
// ======================================================================
// histogram defines
// widths, depths and Bayer swap shared by the histogram design
// ======================================================================
`ifndef HIST_DEFINES_SVH
`define HIST_DEFINES_SVH

`define HIST_PIX_W      8    // pixel width
`define HIST_COLOR_W    2    // bayer color index

// bin address is color above pixel value
`define HIST_ADDR_W     (`HIST_COLOR_W + `HIST_PIX_W)
`define HIST_BINS       1024 // 4 colors x 256 values
`define HIST_BIN_W      12   // counters stop at 4095
`define HIST_DIM_W      16   // window and counter values

// bit 1 flips line parity, bit 0 flips pixel parity
`define HIST_BAYER_XOR  2'b00

`endif

// ==== rtl/hist_pkg.sv ====
// ======================================================================
// histogram package
// bin address union and frame FSM state type
// ======================================================================
`include "hist_defines.svh"

package hist_pkg;

    typedef struct packed {
        logic [`HIST_COLOR_W-1:0] color; // high part, bayer color
        logic [`HIST_PIX_W-1:0]   pix;   // pixel value
    } hist_bin_fld_t;

    // same 10 bits, flat index for the sweep or fields for the accumulator
    typedef union packed {
        logic [`HIST_ADDR_W-1:0] idx;
        hist_bin_fld_t           fld;
    } hist_bin_addr_u;

    typedef enum logic [2:0] {
        S_CLEAR,   // post-reset RAM wipe
        S_IDLE,    // histogram disabled
        S_ARMED,   // waiting for sof
        S_ACCUM,   // window running, then pipeline drain
        S_READOUT  // bins going out over req/ack
    } hist_state_e;

endpackage

// ==== rtl/hist_ram_if.sv ====
// ======================================================================
// histogram RAM read-and-clear port
// readout side reads a bin, accumulator returns it and zeroes it
// ======================================================================
`include "hist_defines.svh"

interface hist_ram_if;

    logic                     rd_en;    // read bin, write back zero
    hist_pkg::hist_bin_addr_u rd_addr;  // flat bin index
    logic [`HIST_BIN_W-1:0]   rd_data;  // one cycle after rd_en
    logic                     rd_valid; // rd_en delayed

    modport rd (
        output rd_en, rd_addr,
        input  rd_data, rd_valid
    );

    modport mem (
        input  rd_en, rd_addr,
        output rd_data, rd_valid
    );

endinterface

// ==== rtl/hist_frame_fsm.sv ====
// ======================================================================
// histogram frame FSM
// sequences RAM clear, arming, accumulation, drain and readout
// ======================================================================
module hist_frame_fsm (
    input  logic pclk,
    input  logic hist_rst_pclk,
    input  logic hist_en_i,     // graceful enable
    input  logic sof_i,
    input  logic win_done_i,    // window closed
    input  logic sweep_done_i,  // readout or clear finished
    output logic frame_go_o,    // armed sof accepted
    output logic sweep_start_o,
    output logic sweep_clear_o, // sweep without handshake
    output logic busy_o
);

    localparam logic [2:0] DRAIN_CYC = 3'd4; // covers the 3-stage update pipe

    hist_pkg::hist_state_e state;
    logic [2:0]            drain_cnt; // nonzero while draining
    logic                  start_r;

    assign frame_go_o    = (state == hist_pkg::S_ARMED) && sof_i; // same cycle as sof
    assign sweep_start_o = start_r;
    assign sweep_clear_o = (state == hist_pkg::S_CLEAR);
    assign busy_o        = (state == hist_pkg::S_ACCUM) || (state == hist_pkg::S_READOUT);

    always_ff @(posedge pclk) begin
        if (hist_rst_pclk) begin
            state     <= hist_pkg::S_CLEAR;
            drain_cnt <= '0;
            start_r   <= 1'b1; // kicks the clear sweep once reset drops
        end else begin
            start_r <= 1'b0;
            case (state)
                hist_pkg::S_CLEAR, hist_pkg::S_READOUT: begin
                    if (sweep_done_i)
                        state <= hist_en_i ? hist_pkg::S_ARMED : hist_pkg::S_IDLE;
                end
                hist_pkg::S_IDLE: begin
                    if (hist_en_i)
                        state <= hist_pkg::S_ARMED;
                end
                hist_pkg::S_ARMED: begin
                    if (frame_go_o)
                        state <= hist_pkg::S_ACCUM;
                    else if (!hist_en_i)
                        state <= hist_pkg::S_IDLE; // not committed yet, safe to drop
                end
                hist_pkg::S_ACCUM: begin
                    if (drain_cnt != '0) begin
                        drain_cnt <= drain_cnt - 1'b1;
                        if (drain_cnt == 3'd1) begin // last write has landed
                            start_r <= 1'b1;
                            state   <= hist_pkg::S_READOUT;
                        end
                    end else if (win_done_i) begin
                        drain_cnt <= DRAIN_CYC;
                    end
                end
                default: state <= hist_pkg::S_CLEAR;
            endcase
        end
    end

endmodule

// ==== rtl/hist_window_cntr.sv ====
// ======================================================================
// histogram window counter
// line and pixel counters, window test, bayer color and window end
// ======================================================================
`include "hist_defines.svh"

module hist_window_cntr (
    input  logic                     pclk,
    input  logic                     hist_rst_pclk,
    input  logic                     frame_go_i,  // latch window, start frame
    input  logic                     eof_i,
    input  logic                     hact_i,
    input  logic [`HIST_PIX_W-1:0]   pix_i,
    input  logic [`HIST_DIM_W-1:0]   left_i,
    input  logic [`HIST_DIM_W-1:0]   top_i,
    input  logic [`HIST_DIM_W-1:0]   width_m1_i,
    input  logic [`HIST_DIM_W-1:0]   height_m1_i,
    output logic                     pix_vld_o,   // pixel inside window
    output logic [`HIST_COLOR_W-1:0] pix_color_o,
    output logic [`HIST_PIX_W-1:0]   pix_data_o,
    output logic                     win_done_o
);

    localparam logic [1:0] BAYER_XOR = `HIST_BAYER_XOR;

    logic [`HIST_DIM_W-1:0] left_q, top_q;
    logic [`HIST_DIM_W:0]   x_last, y_last; // one extra bit, no wrap on right edge
    logic [`HIST_DIM_W-1:0] x_q, y_q;       // next pixel, current line
    logic [`HIST_DIM_W-1:0] x_cur, y_cur;   // position of the pixel at the inputs
    logic                   hact_d, active;
    logic                   line_start, hact_fall, in_win, done_w;

    assign line_start = hact_i && !hact_d;
    assign hact_fall  = !hact_i && hact_d;
    assign x_cur      = hact_d ? x_q : '0;             // restart at each line
    assign y_cur      = line_start ? y_q + 1'b1 : y_q; // y_q starts at all ones

    assign in_win = active && hact_i &&
                    (x_cur >= left_q) && ({1'b0, x_cur} <= x_last) &&
                    (y_cur >= top_q)  && ({1'b0, y_cur} <= y_last);

    // last window line ended, or frame cut short
    assign done_w = active && (eof_i || (hact_fall && ({1'b0, y_q} == y_last)));

    always_ff @(posedge pclk) begin
        if (hist_rst_pclk) begin
            hact_d     <= 1'b0;
            active     <= 1'b0;
            pix_vld_o  <= 1'b0;
            win_done_o <= 1'b0;
        end else begin
            hact_d     <= hact_i;
            pix_vld_o  <= in_win;
            win_done_o <= done_w;
            if (frame_go_i)
                active <= 1'b1;
            else if (done_w)
                active <= 1'b0; // single done pulse per frame
        end
    end

    always_ff @(posedge pclk) begin
        if (frame_go_i) begin
            left_q <= left_i;
            top_q  <= top_i;
            x_last <= {1'b0, left_i} + width_m1_i;
            y_last <= {1'b0, top_i} + height_m1_i;
            y_q    <= '1; // first line start wraps to 0
        end else if (active) begin
            y_q <= y_cur;
        end
        if (hact_i)
            x_q <= x_cur + 1'b1;
        pix_data_o  <= pix_i;
        pix_color_o <= {y_cur[0] ^ BAYER_XOR[1], x_cur[0] ^ BAYER_XOR[0]}; // line, pixel
    end

endmodule

// ==== rtl/hist_bin_accum.sv ====
// ======================================================================
// histogram bin accumulator
// 1024-bin RAM, saturating read-increment-write pipe with forwarding
// and the read-and-clear port used by readout
// ======================================================================
`include "hist_defines.svh"

module hist_bin_accum (
    input  logic                     pclk,
    input  logic                     hist_rst_pclk,
    input  logic                     pix_vld_i,
    input  logic [`HIST_COLOR_W-1:0] pix_color_i,
    input  logic [`HIST_PIX_W-1:0]   pix_data_i,
    hist_ram_if.mem                  ram
);

    logic [`HIST_BIN_W-1:0]   mem [`HIST_BINS];

    hist_pkg::hist_bin_addr_u pix_addr; // built from color and value
    hist_pkg::hist_bin_addr_u raddr;    // shared read address
    hist_pkg::hist_bin_addr_u a1, a2, a3;
    logic                     v1, v2, v3;
    logic [`HIST_BIN_W-1:0]   rd_q;     // RAM read register
    logic [`HIST_BIN_W-1:0]   d2, d3;   // value being written, value just written
    logic [`HIST_BIN_W-1:0]   op, inc;

    always_comb begin
        pix_addr.fld.color = pix_color_i;
        pix_addr.fld.pix   = pix_data_i;
    end

    // clear sweep and accumulation never overlap
    assign raddr = ram.rd_en ? ram.rd_addr : pix_addr;

    // newest in-flight copy of the same bin wins over RAM
    always_comb begin
        if (v2 && (a2.idx == a1.idx))
            op = d2;       // write happens this cycle
        else if (v3 && (a3.idx == a1.idx))
            op = d3;       // written on the edge we read on
        else
            op = rd_q;
    end

    assign inc = (&op) ? op : op + 1'b1; // stick at all ones

    // read-first single port, clear has priority over update
    always_ff @(posedge pclk) begin
        rd_q <= mem[raddr.idx];
        if (ram.rd_en)
            mem[ram.rd_addr.idx] <= '0;
        else if (v2)
            mem[a2.idx] <= d2;
    end

    always_ff @(posedge pclk) begin
        if (hist_rst_pclk) begin
            v1           <= 1'b0;
            v2           <= 1'b0;
            v3           <= 1'b0;
            ram.rd_valid <= 1'b0;
        end else begin
            v1           <= pix_vld_i; // stage 1 RAM read
            v2           <= v1;        // stage 2 increment
            v3           <= v2;        // written, kept for forwarding
            ram.rd_valid <= ram.rd_en;
        end
    end

    always_ff @(posedge pclk) begin
        a1 <= pix_addr;
        a2 <= a1;
        d2 <= inc;
        a3 <= a2;
        d3 <= d2;
    end

    assign ram.rd_data = rd_q;

endmodule

// ==== rtl/hist_readout.sv ====
// ======================================================================
// histogram readout
// sweeps all bins, read-and-clear, four-phase req/ack word output
// ======================================================================
`include "hist_defines.svh"

module hist_readout (
    input  logic                   pclk,
    input  logic                   hist_rst_pclk,
    input  logic                   sweep_start_i,
    input  logic                   sweep_clear_i, // wipe only without handshake
    input  logic                   hist_ack_i,
    output logic                   sweep_done_o,
    output logic                   hist_req_o,
    output logic [`HIST_BIN_W-1:0] hist_data_o,
    hist_ram_if.rd                 ram
);

    localparam logic [1:0] P_IDLE = 2'd0; // waiting for sweep_start
    localparam logic [1:0] P_READ = 2'd1; // read and clear one bin
    localparam logic [1:0] P_LOAD = 2'd2; // word coming back from RAM
    localparam logic [1:0] P_REQ  = 2'd3; // word offered until ack

    logic [1:0]               phase;
    hist_pkg::hist_bin_addr_u idx;
    logic                     last_bin;

    assign last_bin    = &idx.idx;
    assign ram.rd_addr = idx;
    // next bin only after ack has gone low
    assign ram.rd_en   = (phase == P_READ) && (sweep_clear_i || !hist_ack_i);

    always_ff @(posedge pclk) begin
        if (hist_rst_pclk) begin
            phase        <= P_IDLE;
            idx.idx      <= '0;
            hist_req_o   <= 1'b0;
            sweep_done_o <= 1'b0;
        end else begin
            sweep_done_o <= 1'b0;
            case (phase)
                P_IDLE: begin
                    if (sweep_start_i) begin
                        idx.idx <= '0;
                        phase   <= P_READ;
                    end
                end
                P_READ: begin
                    if (ram.rd_en) begin
                        if (!sweep_clear_i) begin
                            phase <= P_LOAD;
                        end else if (last_bin) begin
                            phase        <= P_IDLE;
                            sweep_done_o <= 1'b1;
                        end else begin
                            idx.idx <= idx.idx + 1'b1; // one bin per cycle
                        end
                    end
                end
                P_LOAD: begin
                    if (ram.rd_valid) begin
                        hist_req_o <= 1'b1; // data lands together with req
                        phase      <= P_REQ;
                    end
                end
                P_REQ: begin
                    if (hist_ack_i) begin
                        hist_req_o <= 1'b0;
                        if (last_bin) begin
                            phase        <= P_IDLE;
                            sweep_done_o <= 1'b1;
                        end else begin
                            idx.idx <= idx.idx + 1'b1;
                            phase   <= P_READ;
                        end
                    end
                end
                default: phase <= P_IDLE;
            endcase
        end
    end

    always_ff @(posedge pclk) begin
        if ((phase == P_LOAD) && ram.rd_valid)
            hist_data_o <= ram.rd_data; // held through the whole req phase
    end

endmodule

// ==== rtl/hist_top.sv ====
// ======================================================================
// histogram top
// per-color Bayer histogram with req/ack bin readout
// ======================================================================
`include "hist_defines.svh"

module hist_top (
    input  logic                   pclk,
    input  logic                   hist_rst_pclk,
    input  logic                   hist_en_i,
    input  logic                   sof_i,
    input  logic                   eof_i,
    input  logic                   hact_i,
    input  logic [`HIST_PIX_W-1:0] pix_i,
    input  logic [`HIST_DIM_W-1:0] left_i,
    input  logic [`HIST_DIM_W-1:0] top_i,
    input  logic [`HIST_DIM_W-1:0] width_m1_i,
    input  logic [`HIST_DIM_W-1:0] height_m1_i,
    input  logic                   hist_ack_i,
    output logic                   hist_req_o,
    output logic [`HIST_BIN_W-1:0] hist_data_o,
    output logic                   hist_busy_o
);

    logic                     frame_go, win_done;
    logic                     pix_vld;
    logic [`HIST_COLOR_W-1:0] pix_color;
    logic [`HIST_PIX_W-1:0]   pix_data;
    logic                     sweep_start, sweep_clear, sweep_done;

    hist_ram_if ram_if (); // readout to accumulator

    hist_frame_fsm i_fsm (
        .pclk          (pclk),
        .hist_rst_pclk (hist_rst_pclk),
        .hist_en_i     (hist_en_i),
        .sof_i         (sof_i),
        .win_done_i    (win_done),
        .sweep_done_i  (sweep_done),
        .frame_go_o    (frame_go),
        .sweep_start_o (sweep_start),
        .sweep_clear_o (sweep_clear),
        .busy_o        (hist_busy_o)
    );

    hist_window_cntr i_win (
        .pclk          (pclk),
        .hist_rst_pclk (hist_rst_pclk),
        .frame_go_i    (frame_go),
        .eof_i         (eof_i),
        .hact_i        (hact_i),
        .pix_i         (pix_i),
        .left_i        (left_i),
        .top_i         (top_i),
        .width_m1_i    (width_m1_i),
        .height_m1_i   (height_m1_i),
        .pix_vld_o     (pix_vld),
        .pix_color_o   (pix_color),
        .pix_data_o    (pix_data),
        .win_done_o    (win_done)
    );

    hist_bin_accum i_accum (
        .pclk          (pclk),
        .hist_rst_pclk (hist_rst_pclk),
        .pix_vld_i     (pix_vld),
        .pix_color_i   (pix_color),
        .pix_data_i    (pix_data),
        .ram           (ram_if.mem)
    );

    hist_readout i_readout (
        .pclk          (pclk),
        .hist_rst_pclk (hist_rst_pclk),
        .sweep_start_i (sweep_start),
        .sweep_clear_i (sweep_clear),
        .hist_ack_i    (hist_ack_i),
        .sweep_done_o  (sweep_done),
        .hist_req_o    (hist_req_o),
        .hist_data_o   (hist_data_o),
        .ram           (ram_if.rd)
    );

endmodule

// ==== sim/hist_assert.sv ====
// ======================================================================
// histogram handshake assertions
// four-phase req/ack protocol checks, bound into the top level
// ======================================================================
`include "hist_defines.svh"

module hist_assert (
    input logic                   pclk,
    input logic                   hist_rst_pclk,
    input logic                   req_i,   // hist_req_o of the DUT
    input logic                   ack_i,   // consumer ack
    input logic [`HIST_BIN_W-1:0] data_i   // word under req
);

    // req held until the consumer acks
    a_req_hold: assert property (@(posedge pclk) disable iff (hist_rst_pclk)
        (req_i && !ack_i) |=> req_i)
        else $error("hist_req_o fell while hist_ack_i was low");

    // word frozen while waiting for ack
    a_data_stable: assert property (@(posedge pclk) disable iff (hist_rst_pclk)
        (req_i && !ack_i) |=> $stable(data_i))
        else $error("hist_data_o changed while hist_req_o waited for hist_ack_i");

    // next word only after ack is back low
    a_req_rise: assert property (@(posedge pclk) disable iff (hist_rst_pclk)
        (!req_i && ack_i) |=> !req_i)
        else $error("hist_req_o rose while hist_ack_i was high");

endmodule

bind hist_top hist_assert i_assert (
    .pclk          (pclk),
    .hist_rst_pclk (hist_rst_pclk),
    .req_i         (hist_req_o),
    .ack_i         (hist_ack_i),
    .data_i        (hist_data_o)
);

// ==== sim/hist_tb.sv ====
// ======================================================================
// histogram testbench
// frame table driver, per-bin reference model and req/ack readout check
// ======================================================================
`include "hist_defines.svh"

module hist_tb;

    localparam int TMO = 4000;                         // cycles per wait
    localparam int ROWS = 7;
    localparam logic [1:0] BAYER_XOR = `HIST_BAYER_XOR;

    typedef struct {
        int fw, fh;                 // frame size
        int left, top, wm1, hm1;    // window
        int kind;                   // 0 ramp, 1 constant, 2 random
        int pval;                   // constant pixel
        bit en, rdo, skip;          // enable, read out after, sent during readout
    } frame_row_t;

    logic                   pclk;
    logic                   hist_rst_pclk;
    logic                   hist_en_i, sof_i, eof_i, hact_i;
    logic [`HIST_PIX_W-1:0] pix_i;
    logic [`HIST_DIM_W-1:0] left_i, top_i, width_m1_i, height_m1_i;
    logic                   hist_ack_i;
    logic                   hist_req_o, hist_busy_o;
    logic [`HIST_BIN_W-1:0] hist_data_o;

    frame_row_t             rows [ROWS];
    logic [`HIST_BIN_W-1:0] model [`HIST_BINS]; // expected bins
    int                     errors, words, seed;
    int                     exp_total;          // pixels in window or -1 when clipped
    bit                     abort, quiet, quiet_seen;

    hist_top i_dut (
        .pclk (pclk), .hist_rst_pclk (hist_rst_pclk), .hist_en_i (hist_en_i),
        .sof_i (sof_i), .eof_i (eof_i), .hact_i (hact_i), .pix_i (pix_i),
        .left_i (left_i), .top_i (top_i), .width_m1_i (width_m1_i),
        .height_m1_i (height_m1_i), .hist_ack_i (hist_ack_i), .hist_req_o (hist_req_o),
        .hist_data_o (hist_data_o), .hist_busy_o (hist_busy_o)
    );

    initial begin
        pclk = 1'b0;
        forever #4 pclk = ~pclk;
    end

    // disabled frames must leave the outputs quiet
    always @(negedge pclk) begin
        if (quiet && !quiet_seen && (hist_busy_o || hist_req_o)) begin
            $display("disabled frame woke the histogram, busy %0b req %0b",
                     hist_busy_o, hist_req_o);
            errors++;
            quiet_seen = 1'b1;
        end
    end

    task automatic set_row(input int r, input int fw, input int fh, input int left,
                           input int top, input int wm1, input int hm1, input int kind,
                           input int pval, input bit en, input bit rdo, input bit skip);
        rows[r] = '{fw, fh, left, top, wm1, hm1, kind, pval, en, rdo, skip};
    endtask

    task automatic wait_req(input logic lvl);
        int n;
        n = 0;
        do begin
            @(negedge pclk);
            n++;
        end while ((hist_req_o !== lvl) && (n < TMO));
        if (hist_req_o !== lvl) begin
            $display("timeout waiting for hist_req_o to become %0b", lvl);
            errors++;
            abort = 1'b1;
        end
    endtask

    task automatic wait_not_busy();
        int n;
        n = 0;
        do begin
            @(negedge pclk);
            n++;
        end while ((hist_busy_o !== 1'b0) && (n < TMO));
        if (hist_busy_o !== 1'b0) begin
            $display("timeout waiting for hist_busy_o to drop after readout");
            errors++;
            abort = 1'b1;
        end
    endtask

    task automatic drive_frame(input int r);
        frame_row_t              f;
        logic [`HIST_PIX_W-1:0]  p;
        logic [`HIST_ADDR_W-1:0] b;
        bit                      count, in_window;
        f = rows[r];
        count = f.en && !f.skip;                       // skipped frames add nothing
        @(posedge pclk);
        sof_i       <= 1'b1;
        left_i      <= `HIST_DIM_W'(f.left);
        top_i       <= `HIST_DIM_W'(f.top);
        width_m1_i  <= `HIST_DIM_W'(f.wm1);
        height_m1_i <= `HIST_DIM_W'(f.hm1);
        @(posedge pclk);
        sof_i <= 1'b0;
        @(negedge pclk);
        if (hist_busy_o !== f.en) begin
            $display("Mismatch hist_busy_o after sof: got %0h expected %0h", hist_busy_o, f.en);
            errors++;
        end
        for (int y = 0; y < f.fh; y++) begin
            for (int x = 0; x < f.fw; x++) begin
                case (f.kind)
                    0:       p = `HIST_PIX_W'(x + 3 * y);  // diagonal ramp
                    1:       p = `HIST_PIX_W'(f.pval);
                    default: p = `HIST_PIX_W'($random(seed));
                endcase
                @(posedge pclk);
                hact_i <= 1'b1;
                pix_i  <= p;
                in_window = (x >= f.left) && (x <= f.left + f.wm1) &&
                            (y >= f.top) && (y <= f.top + f.hm1);
                if (count && in_window) begin
                    b = {y[0] ^ BAYER_XOR[1], x[0] ^ BAYER_XOR[0], p}; // color over value
                    if (model[b] != '1)
                        model[b] = model[b] + 1'b1;             // counters stop at all ones
                end
            end
            @(posedge pclk);
            hact_i <= 1'b0;
            repeat (3) @(posedge pclk);                 // line blank
        end
        @(posedge pclk);
        eof_i <= 1'b1;
        @(posedge pclk);
        eof_i <= 1'b0;
        if (count) begin
            if ((f.left + f.wm1 < f.fw) && (f.top + f.hm1 < f.fh))
                exp_total = (f.wm1 + 1) * (f.hm1 + 1);
            else
                exp_total = -1;                          // window clipped by frame
        end
    endtask

    task automatic check_readout();
        int sum;
        int dly;
        bit sat;
        sum = 0;
        sat = 1'b0;
        for (int i = 0; (i < `HIST_BINS) && !abort; i++) begin
            wait_req(1'b1);
            if (!abort) begin
                if (hist_data_o !== model[i]) begin
                    $display("Mismatch hist_data_o bin %03h: got %03h expected %03h",
                             i, hist_data_o, model[i]);
                    errors++;
                end
                sum += int'(hist_data_o);
                if (&hist_data_o)
                    sat = 1'b1;
                words++;
                model[i] = '0;                          // read clears the bin
                dly = $random(seed) & 3;                // slow consumer now and then
                repeat (dly) @(posedge pclk);
                @(posedge pclk);
                hist_ack_i <= 1'b1;
                wait_req(1'b0);
                @(posedge pclk);
                hist_ack_i <= 1'b0;
            end
        end
        if (!abort)
            wait_not_busy();
        if (!abort && !sat && (exp_total >= 0) && (sum != exp_total)) begin
            $display("Mismatch readout sum: got %0h expected %0h", sum, exp_total);
            errors++;
        end
    endtask

    initial begin
        seed          = 32'h4f1a61bd;
        errors        = 0;
        words         = 0;
        exp_total     = -1;
        abort         = 1'b0;
        quiet         = 1'b0;
        quiet_seen    = 1'b0;
        hist_rst_pclk <= 1'b1;
        hist_en_i     <= 1'b0;
        sof_i         <= 1'b0;
        eof_i         <= 1'b0;
        hact_i        <= 1'b0;
        pix_i         <= '0;
        left_i        <= '0;
        top_i         <= '0;
        width_m1_i    <= '0;
        height_m1_i   <= '0;
        hist_ack_i    <= 1'b0;
        for (int i = 0; i < `HIST_BINS; i++)
            model[i] = '0;
        //      r  fw   fh left top wm1  hm1 kind pval  en rdo skip
        set_row(0,  32,  16,  0,  0,  31,  15, 0,    0, 0, 0, 0); // disabled
        set_row(1,  48,  24,  5,  3,  29,  14, 0,    0, 1, 1, 0); // offset ramp
        set_row(2,  64,  80,  0,  0,  63,  79, 1, 'h5a, 1, 1, 0); // 1280 per color
        set_row(3, 176, 112,  8,  4, 159, 103, 1, 'h5a, 1, 1, 0); // saturates
        set_row(4,  40,  30,  2,  2,  35,  25, 2,    0, 1, 0, 0); // random and read later
        set_row(5,  32,  16,  0,  0,  31,  15, 0,    0, 1, 0, 1); // sof during readout
        set_row(6,  40,  20,  4,  1,  50,  30, 0,    0, 1, 1, 0); // clipped so eof ends it
        repeat (4) @(posedge pclk);
        hist_rst_pclk <= 1'b0;
        repeat (1100) @(posedge pclk);                  // clear sweep takes 1025
        for (int r = 0; (r < ROWS) && !abort; r++) begin
            @(posedge pclk);
            hist_en_i <= rows[r].en;
            repeat (3) @(posedge pclk);
            quiet      = !rows[r].en;
            quiet_seen = 1'b0;
            if (rows[r].skip) begin
                fork
                    check_readout();                    // previous frame going out
                    begin
                        wait_req(1'b1);
                        if (!abort)
                            drive_frame(r);
                    end
                join
            end else begin
                drive_frame(r);
                if (rows[r].rdo)
                    check_readout();
            end
            repeat (20) @(posedge pclk);
            quiet = 1'b0;
        end
        $display("errors %0d, words checked %0d", errors, words);
        if (errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== hist.f ====
+incdir+rtl
rtl/hist_pkg.sv
rtl/hist_ram_if.sv
rtl/hist_frame_fsm.sv
rtl/hist_window_cntr.sv
rtl/hist_bin_accum.sv
rtl/hist_readout.sv
rtl/hist_top.sv
sim/hist_assert.sv
sim/hist_tb.sv

// ==== run_sim.sh ====
#!/bin/bash
# build the histogram testbench with Verilator, run it, judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module hist_tb -f hist.f -o hist_sim \
    && ./obj_dir/hist_sim > sim.log 2>&1 \
    || echo "build or simulation stopped early"

grep -qx "TEST OK" sim.log \
    && echo "histogram simulation passed" \
    || { echo "histogram simulation failed, see sim.log"; exit 1; }
